// File: rtl/sw_cfg.svh
`ifndef SW_CFG_SVH
`define SW_CFG_SVH
`default_nettype none

// array size, one PE per query base
`define SW_NUM_PE    64

// datapath widths
`define SW_SCORE_W   14
`define SW_POS_W     10

// affine gap and substitution scores
`define SW_GAP_OPEN  (-12)
`define SW_GAP_EXT   (-1)
`define SW_MATCH     2
`define SW_MISMATCH  (-3)

// stop when a diagonal falls this far below the running max
`define SW_XDROP     250

// longest reference a job may stream
`define SW_MAX_REF   400

`default_nettype wire
`endif

// File: rtl/sw_pkg.sv
`include "sw_cfg.svh"
`default_nettype none

package sw_pkg;

    // signed alignment score
    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    // nucleotide code
    typedef logic [1:0] base_t;

    // diagonal index
    typedef logic [`SW_POS_W-1:0] pos_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CALC = 2'd1,
        DONE = 2'd2
    } ctrl_state_t;

    // empty boundary and masked PE value, -4096 at 14 bits
    localparam score_t NEG_INF = {2'b11, {(`SW_SCORE_W-2){1'b0}}};

endpackage

`default_nettype wire

// File: rtl/sw_pe.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_pe (
    input  wire sw_pkg::base_t  i_q_base,
    input  wire sw_pkg::base_t  i_r_base,
    input  wire sw_pkg::score_t i_v_diag,
    input  wire sw_pkg::score_t i_v_top,
    input  wire sw_pkg::score_t i_v_left,
    input  wire sw_pkg::score_t i_i_left,
    input  wire sw_pkg::score_t i_d_top,
    output sw_pkg::score_t      o_v,
    output sw_pkg::score_t      o_i,
    output sw_pkg::score_t      o_d
);

    sw_pkg::score_t sub;
    sw_pkg::score_t i_from_v;
    sw_pkg::score_t i_from_i;
    sw_pkg::score_t d_from_v;
    sw_pkg::score_t d_from_d;
    sw_pkg::score_t v_match;

    // substitution score
    assign sub = (i_q_base == i_r_base) ? sw_pkg::score_t'(`SW_MATCH)
                                        : sw_pkg::score_t'(`SW_MISMATCH);

    // insertion, gap running along the reference
    assign i_from_v = i_v_left + sw_pkg::score_t'(`SW_GAP_OPEN);
    assign i_from_i = i_i_left + sw_pkg::score_t'(`SW_GAP_EXT);
    assign o_i      = (i_from_v > i_from_i) ? i_from_v : i_from_i;

    // deletion, gap running down the query
    assign d_from_v = i_v_top + sw_pkg::score_t'(`SW_GAP_OPEN);
    assign d_from_d = i_d_top + sw_pkg::score_t'(`SW_GAP_EXT);
    assign o_d      = (d_from_v > d_from_d) ? d_from_v : d_from_d;

    assign v_match = i_v_diag + sub;

    always_comb begin
        o_v = v_match;
        if (o_i > o_v) begin
            o_v = o_i;
        end
        if (o_d > o_v) begin
            o_v = o_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sw_max_tree.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_max_tree (
    input  wire logic [`SW_NUM_PE*`SW_SCORE_W-1:0] i_scores,
    output sw_pkg::score_t                         o_max
);

    localparam int N   = `SW_NUM_PE;
    localparam int W   = `SW_SCORE_W;
    localparam int LVL = $clog2(N);

    // layer 0 holds the leaves, each later layer halves the node count
    // the last layer is the single root node
    for (genvar l = 0; l <= LVL; l++) begin : g_lvl
        sw_pkg::score_t node [N >> l];
        for (genvar k = 0; k < (N >> l); k++) begin : g_node
            if (l == 0) begin : g_leaf
                assign node[k] = sw_pkg::score_t'(i_scores[k*W +: W]);
            end else begin : g_max
                assign node[k] = (g_lvl[l-1].node[2*k] > g_lvl[l-1].node[2*k+1])
                               ? g_lvl[l-1].node[2*k] : g_lvl[l-1].node[2*k+1];
            end
        end
    end

    assign o_max = g_lvl[LVL].node[0];

endmodule

`default_nettype wire

// File: rtl/sw_pe_array.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_pe_array (
    input  wire logic                               i_clk,
    input  wire logic                               i_rst,
    input  wire logic                               i_load_query,
    input  wire logic [2*`SW_NUM_PE-1:0]            i_query,
    input  wire logic                               i_inj_valid,
    input  wire sw_pkg::base_t                      i_inj_base,
    input  wire sw_pkg::score_t                     i_top_v,
    input  wire sw_pkg::score_t                     i_diag_v,
    input  wire sw_pkg::score_t                     i_top_d,
    input  wire sw_pkg::score_t                     i_left_v,
    output logic [`SW_NUM_PE*`SW_SCORE_W-1:0]       o_scores,
    output logic                                    o_last_pe_en
);

    localparam int N = `SW_NUM_PE;
    localparam int W = `SW_SCORE_W;

    sw_pkg::base_t  q_base  [N];
    // base each PE held last cycle, passed on to its neighbour
    sw_pkg::base_t  r_base  [N-1];
    sw_pkg::base_t  base_in [N];

    // en_sr[k] means PE k updated its registers at the last edge
    logic [N-1:0]   en_sr;
    logic [N-1:0]   en_in;
    logic [N-1:0]   first;

    sw_pkg::score_t v_r    [N];
    sw_pkg::score_t i_r    [N];
    sw_pkg::score_t d_r    [N];
    sw_pkg::score_t dg_r   [1:N-1];
    sw_pkg::score_t v_left [N];
    sw_pkg::score_t i_left [N];
    sw_pkg::score_t v_top  [N];
    sw_pkg::score_t v_diag [N];
    sw_pkg::score_t d_top  [N];
    sw_pkg::score_t v_nxt  [N];
    sw_pkg::score_t i_nxt  [N];
    sw_pkg::score_t d_nxt  [N];

    always_comb begin
        en_in[0]   = i_inj_valid;
        base_in[0] = i_inj_base;
        v_top[0]   = i_top_v;
        v_diag[0]  = i_diag_v;
        d_top[0]   = i_top_d;
        for (int k = 1; k < N; k++) begin
            en_in[k]   = en_sr[k-1];
            base_in[k] = r_base[k-1];
            v_top[k]   = v_r[k-1];
            v_diag[k]  = dg_r[k];
            d_top[k]   = d_r[k-1];
        end
        // a PE's enabled run is gapless, so a rising enable is column 1
        first = en_in & ~en_sr;
        for (int k = 0; k < N; k++) begin
            v_left[k] = first[k] ? i_left_v : v_r[k];
            i_left[k] = first[k] ? sw_pkg::NEG_INF : i_r[k];
            o_scores[k*W +: W] = en_sr[k] ? v_r[k] : sw_pkg::NEG_INF;
        end
    end

    assign o_last_pe_en = en_sr[N-1];

    // wavefront
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            en_sr <= '0;
        end else if (i_load_query) begin
            en_sr <= '0;
        end else begin
            en_sr <= en_in;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load_query) begin
            for (int k = 0; k < N; k++) begin
                q_base[k] <= i_query[2*k +: 2];
            end
        end
        for (int k = 0; k < N-1; k++) begin
            r_base[k] <= base_in[k];
        end
        for (int k = 0; k < N; k++) begin
            if (en_in[k]) begin
                v_r[k] <= v_nxt[k];
                i_r[k] <= i_nxt[k];
                d_r[k] <= d_nxt[k];
            end
        end
        // diagonal delay, seeded with the upper PE's left boundary
        for (int k = 1; k < N; k++) begin
            if (en_in[k]) begin
                dg_r[k] <= v_r[k-1];
            end else if (first[k-1]) begin
                dg_r[k] <= v_left[k-1];
            end
        end
    end

    for (genvar k = 0; k < N; k++) begin : g_pe
        sw_pe u_pe (
            .i_q_base (q_base[k]),
            .i_r_base (base_in[k]),
            .i_v_diag (v_diag[k]),
            .i_v_top  (v_top[k]),
            .i_v_left (v_left[k]),
            .i_i_left (i_left[k]),
            .i_d_top  (d_top[k]),
            .o_v      (v_nxt[k]),
            .o_i      (i_nxt[k]),
            .o_d      (d_nxt[k])
        );
    end

    // gapless injection keeps the active PEs in one run
    a_en_contig : assert property (@(posedge i_clk) disable iff (i_rst)
        $countones(en_sr ^ (en_sr >> 1)) <= 2);

endmodule

`default_nettype wire

// File: rtl/sw_stripe_ctrl.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_stripe_ctrl (
    input  wire logic           i_clk,
    input  wire logic           i_rst,
    input  wire logic           i_start,
    input  wire logic           i_ref_valid,
    input  wire sw_pkg::base_t  i_ref_base,
    input  wire logic           i_ref_last,
    input  wire sw_pkg::score_t i_diag_max,
    input  wire logic           i_last_pe_en,
    output logic                o_load_query,
    output logic                o_inj_valid,
    output sw_pkg::base_t       o_inj_base,
    output sw_pkg::score_t      o_top_v,
    output sw_pkg::score_t      o_diag_v,
    output sw_pkg::score_t      o_top_d,
    output sw_pkg::score_t      o_left_v,
    output logic                o_busy,
    output logic                o_done,
    output sw_pkg::score_t      o_max_score,
    output sw_pkg::pos_t        o_end_diag,
    output logic                o_xdrop
);

    sw_pkg::ctrl_state_t state;
    sw_pkg::pos_t        diag_cnt;
    sw_pkg::score_t      local_max;
    sw_pkg::score_t      new_max;
    sw_pkg::score_t      drop_lvl;
    logic                eval_on;
    logic                ref_done;
    logic                last_pe_q;
    logic                pe_fall;
    logic                calc_on;
    logic                eval;
    logic                stop;

    assign o_load_query = i_start && (state == sw_pkg::IDLE);
    assign o_inj_valid  = (state == sw_pkg::CALC) && i_ref_valid;
    assign o_inj_base   = i_ref_base;
    assign o_top_d      = sw_pkg::NEG_INF;
    assign o_busy       = (state != sw_pkg::IDLE);
    assign o_max_score  = local_max;

    // last PE finished its final column
    assign pe_fall = last_pe_q && !i_last_pe_en && ref_done;
    assign calc_on = (state == sw_pkg::CALC) && eval_on;
    assign eval    = calc_on && !pe_fall;

    // X-drop test against the max including this diagonal
    assign new_max  = (i_diag_max > local_max) ? i_diag_max : local_max;
    assign drop_lvl = new_max - sw_pkg::score_t'(`SW_XDROP);
    assign stop     = (i_diag_max < drop_lvl);

    // boundary row and column scores by running adders
    always_ff @(posedge i_clk) begin
        if (o_load_query) begin
            o_top_v  <= sw_pkg::score_t'(`SW_GAP_OPEN);
            o_diag_v <= '0;
            o_left_v <= sw_pkg::score_t'(`SW_GAP_OPEN);
        end else begin
            if (o_inj_valid) begin
                o_diag_v <= o_top_v;
                o_top_v  <= o_top_v + sw_pkg::score_t'(`SW_GAP_EXT);
            end
            // one more PE reaches column 1 each cycle
            if (o_inj_valid || calc_on) begin
                o_left_v <= o_left_v + sw_pkg::score_t'(`SW_GAP_EXT);
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state      <= sw_pkg::IDLE;
            diag_cnt   <= '0;
            local_max  <= sw_pkg::NEG_INF;
            eval_on    <= 1'b0;
            ref_done   <= 1'b0;
            last_pe_q  <= 1'b0;
            o_done     <= 1'b0;
            o_end_diag <= '0;
            o_xdrop    <= 1'b0;
        end else begin
            o_done    <= 1'b0;
            last_pe_q <= i_last_pe_en;
            if (i_ref_valid && i_ref_last) begin
                ref_done <= 1'b1;
            end
            case (state)
                sw_pkg::IDLE: begin
                    if (i_start) begin
                        state      <= sw_pkg::CALC;
                        diag_cnt   <= '0;
                        local_max  <= sw_pkg::NEG_INF;
                        eval_on    <= 1'b0;
                        ref_done   <= 1'b0;
                        last_pe_q  <= 1'b0;
                        o_end_diag <= '0;
                        o_xdrop    <= 1'b0;
                    end
                end
                sw_pkg::CALC: begin
                    // first diagonal is ready the cycle after the first base
                    if (o_inj_valid) begin
                        eval_on <= 1'b1;
                    end
                    if (eval) begin
                        diag_cnt  <= diag_cnt + sw_pkg::pos_t'(1);
                        local_max <= new_max;
                        if (stop) begin
                            state      <= sw_pkg::DONE;
                            o_end_diag <= diag_cnt;
                            o_xdrop    <= 1'b1;
                        end
                    end
                    if (pe_fall) begin
                        state      <= sw_pkg::DONE;
                        o_end_diag <= diag_cnt - sw_pkg::pos_t'(1);
                    end
                end
                sw_pkg::DONE: begin
                    // drain what is left of the reference stream
                    if (ref_done || (i_ref_valid && i_ref_last)) begin
                        state  <= sw_pkg::IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: begin
                    state <= sw_pkg::IDLE;
                end
            endcase
        end
    end

    // driver sends bases only inside a job
    a_no_ref_idle : assert property (@(posedge i_clk) disable iff (i_rst)
        (state == sw_pkg::IDLE) |-> !i_ref_valid);

endmodule

`default_nettype wire

// File: rtl/sw_top.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_top (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst,
    input  wire logic                    i_start,
    input  wire logic [2*`SW_NUM_PE-1:0] i_query,
    input  wire logic                    i_ref_valid,
    input  wire sw_pkg::base_t           i_ref_base,
    input  wire logic                    i_ref_last,
    output logic                         o_busy,
    output logic                         o_done,
    output sw_pkg::score_t               o_max_score,
    output sw_pkg::pos_t                 o_end_diag,
    output logic                         o_xdrop
);

    logic                                load_query;
    logic                                inj_valid;
    sw_pkg::base_t                       inj_base;
    sw_pkg::score_t                      top_v;
    sw_pkg::score_t                      diag_v;
    sw_pkg::score_t                      top_d;
    sw_pkg::score_t                      left_v;
    logic [`SW_NUM_PE*`SW_SCORE_W-1:0]   scores;
    logic                                last_pe_en;
    sw_pkg::score_t                      diag_max;

    sw_stripe_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_ref_valid  (i_ref_valid),
        .i_ref_base   (i_ref_base),
        .i_ref_last   (i_ref_last),
        .i_diag_max   (diag_max),
        .i_last_pe_en (last_pe_en),
        .o_load_query (load_query),
        .o_inj_valid  (inj_valid),
        .o_inj_base   (inj_base),
        .o_top_v      (top_v),
        .o_diag_v     (diag_v),
        .o_top_d      (top_d),
        .o_left_v     (left_v),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_max_score  (o_max_score),
        .o_end_diag   (o_end_diag),
        .o_xdrop      (o_xdrop)
    );

    sw_pe_array u_array (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_query (load_query),
        .i_query      (i_query),
        .i_inj_valid  (inj_valid),
        .i_inj_base   (inj_base),
        .i_top_v      (top_v),
        .i_diag_v     (diag_v),
        .i_top_d      (top_d),
        .i_left_v     (left_v),
        .o_scores     (scores),
        .o_last_pe_en (last_pe_en)
    );

    sw_max_tree u_tree (
        .i_scores (scores),
        .o_max    (diag_max)
    );

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
    end

    // free running, first rising edge after half a period
    always begin
        #(PERIOD_NS / 2);
        o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// File: dv/sw_tb.sv
`include "sw_cfg.svh"
`default_nettype none

module sw_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N         = `SW_NUM_PE;
    localparam int NEG       = -4096;
    localparam int PERIOD_NS = 100;
    localparam int RST_CYC   = 5;
    // reference bases summed over every job, and the job count
    localparam int TOTAL_REF = 100 + 200 + 320 + 50 + 130;
    localparam int NUM_JOBS  = 5;
    localparam int WD_NS     = (RST_CYC + TOTAL_REF + 2 * N * NUM_JOBS) * PERIOD_NS * 3 / 2;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_start;
    logic [2*N-1:0]       i_query;
    logic                 i_ref_valid;
    sw_pkg::base_t        i_ref_base;
    logic                 i_ref_last;
    logic                 o_busy;
    logic                 o_done;
    sw_pkg::score_t       o_max_score;
    sw_pkg::pos_t         o_end_diag;
    logic                 o_xdrop;

    logic [1:0]           qry     [0:N-1];
    logic [1:0]           ref_seq [0:`SW_MAX_REF-1];
    int                   ref_len;

    // model matrices, row 0 and column 0 are the boundaries
    int                   v_m [0:N][0:`SW_MAX_REF];
    int                   i_m [0:N][0:`SW_MAX_REF];
    int                   d_m [0:N][0:`SW_MAX_REF];
    int                   exp_max;
    int                   exp_end;
    int                   exp_xdrop;

    int                   done_cnt;
    int                   got_max;
    int                   got_end;
    int                   got_xdrop;

    tb_clkgen #(.PERIOD_NS(PERIOD_NS)) u_clkgen (.o_clk(i_clk));

    sw_top dut0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_query     (i_query),
        .i_ref_valid (i_ref_valid),
        .i_ref_base  (i_ref_base),
        .i_ref_last  (i_ref_last),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_max_score (o_max_score),
        .o_end_diag  (o_end_diag),
        .o_xdrop     (o_xdrop)
    );

    // count done pulses and capture results while done is high
    initial begin
        done_cnt = 0;
    end

    always @(negedge i_clk) begin
        if (o_done) begin
            done_cnt  = done_cnt + 1;
            got_max   = int'(o_max_score);
            got_end   = int'(o_end_diag);
            got_xdrop = int'(o_xdrop);
        end
    end

    task automatic check(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    function automatic logic [1:0] rand_base(input int top);
        return 2'($urandom_range(top, 0));
    endfunction

    // full affine-gap matrices, then a diagonal scan for the stop rule
    task automatic run_model();
        int s;
        int c;
        int dmax;
        int best;
        v_m[0][0] = 0;
        i_m[0][0] = NEG;
        d_m[0][0] = NEG;
        for (int k = 1; k <= ref_len; k++) begin
            v_m[0][k] = `SW_GAP_OPEN + `SW_GAP_EXT * (k - 1);
            i_m[0][k] = NEG;
            d_m[0][k] = NEG;
        end
        for (int k = 1; k <= N; k++) begin
            v_m[k][0] = `SW_GAP_OPEN + `SW_GAP_EXT * (k - 1);
            i_m[k][0] = NEG;
            d_m[k][0] = NEG;
        end
        for (int r = 1; r <= N; r++) begin
            for (int cc = 1; cc <= ref_len; cc++) begin
                s = (qry[r-1] == ref_seq[cc-1]) ? `SW_MATCH : `SW_MISMATCH;
                i_m[r][cc] = larger(v_m[r][cc-1] + `SW_GAP_OPEN, i_m[r][cc-1] + `SW_GAP_EXT);
                d_m[r][cc] = larger(v_m[r-1][cc] + `SW_GAP_OPEN, d_m[r-1][cc] + `SW_GAP_EXT);
                v_m[r][cc] = larger(larger(v_m[r-1][cc-1] + s, i_m[r][cc]), d_m[r][cc]);
            end
        end
        best      = NEG;
        exp_xdrop = 0;
        exp_end   = ref_len + N - 2;
        for (int d = 0; d <= ref_len + N - 2; d++) begin
            dmax = NEG;
            for (int r = 1; r <= N; r++) begin
                c = d + 2 - r;
                if (c >= 1 && c <= ref_len) begin
                    dmax = larger(dmax, v_m[r][c]);
                end
            end
            best = larger(best, dmax);
            if (dmax < best - `SW_XDROP) begin
                exp_xdrop = 1;
                exp_end   = d;
                break;
            end
        end
        exp_max = best;
    endtask

    // start pulse, gapless base stream, then wait for done
    task automatic run_job();
        int wait_cnt;
        int start_cnt;
        run_model();
        @(negedge i_clk);
        for (int k = 0; k < N; k++) begin
            i_query[2*k +: 2] = qry[k];
        end
        start_cnt = done_cnt;
        i_start   = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        check("o_busy", int'(o_busy), 1);
        for (int j = 0; j < ref_len; j++) begin
            i_ref_valid = 1'b1;
            i_ref_base  = ref_seq[j];
            i_ref_last  = (j == ref_len - 1);
            @(negedge i_clk);
        end
        i_ref_valid = 1'b0;
        i_ref_last  = 1'b0;
        wait_cnt    = 0;
        while (done_cnt == start_cnt) begin
            @(posedge i_clk);
            wait_cnt++;
            if (wait_cnt > 4 * N) begin
                $display("no done pulse within %0d cycles after the last base", 4 * N);
                $display("sim failed");
                $fatal(1, "done wait expired");
            end
        end
        @(negedge i_clk);
        // done is a single-cycle pulse
        check("o_done", int'(o_done), 0);
        check("o_max_score", got_max, exp_max);
        check("o_xdrop", got_xdrop, exp_xdrop);
        check("o_end_diag", got_end, exp_end);
        check("o_busy", int'(o_busy), 0);
    endtask

    task automatic test_reset_state();
        check("o_busy", int'(o_busy), 0);
        check("o_done", int'(o_done), 0);
        check("o_xdrop", int'(o_xdrop), 0);
        check("o_max_score", int'(o_max_score), NEG);
    endtask

    // full-length match scores MATCH on every query base
    task automatic test_identical_ref();
        for (int k = 0; k < N; k++) begin
            qry[k] = rand_base(3);
        end
        ref_len = 100;
        for (int j = 0; j < ref_len; j++) begin
            ref_seq[j] = (j < N) ? qry[j] : rand_base(3);
        end
        run_job();
        check("o_max_score", got_max, `SW_MATCH * N);
        check("o_xdrop", got_xdrop, 0);
    endtask

    task automatic test_random_pair(input int len);
        for (int k = 0; k < N; k++) begin
            qry[k] = rand_base(3);
        end
        ref_len = len;
        for (int j = 0; j < ref_len; j++) begin
            ref_seq[j] = rand_base(3);
        end
        run_job();
    endtask

    // query never holds base 3, so the tail mismatches every row
    task automatic test_xdrop_stop();
        for (int k = 0; k < N; k++) begin
            qry[k] = rand_base(2);
        end
        ref_len = 320;
        for (int j = 0; j < ref_len; j++) begin
            ref_seq[j] = (j < 20) ? qry[j] : 2'd3;
        end
        run_job();
        check("o_xdrop", got_xdrop, 1);
    endtask

    task automatic test_back_to_back();
        test_random_pair(50);
        @(negedge i_clk);
        check("o_busy", int'(o_busy), 0);
        test_random_pair(130);
    endtask

    initial begin
        void'($urandom(91656));
        i_rst       = 1'b1;
        i_start     = 1'b0;
        i_query     = '0;
        i_ref_valid = 1'b0;
        i_ref_base  = '0;
        i_ref_last  = 1'b0;
        repeat (RST_CYC) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        test_reset_state();
        test_identical_ref();
        test_random_pair(200);
        test_xdrop_stop();
        test_back_to_back();
        $display("sim passed");
        $finish;
    end

    initial begin
        #(WD_NS);
        $display("timeout after %0d ns, the tests did not finish", WD_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/sw_pkg.sv
rtl/sw_pe.sv
rtl/sw_max_tree.sv
rtl/sw_pe_array.sv
rtl/sw_stripe_ctrl.sv
rtl/sw_top.sv
dv/tb_clkgen.sv
dv/sw_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = sw_tb
FILELIST  = all.f
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
